// ==== decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define GROUP_WIDTH  2             // instructions per fetch group
`define BUNDLE_WIDTH 4             // two cracked instructions fit
`define INSN_BITS    32
`define NUM_REGS     32
`define SP_REG       5'd31

// bits 31:22
`define PAT_ADD_RI 10'b1001000100
`define PAT_SUB_RI 10'b1101000100

// bits 31:21, cmp and cmn share the adds/subs encodings
`define PAT_ADDS 11'b10101011000
`define PAT_SUBS 11'b11101011000
`define PAT_ORR  11'b10101010000
`define PAT_MVN  11'b10101010001
`define PAT_EOR  11'b11001010000
`define PAT_ANDS 11'b11101010000
`define PAT_LDUR 11'b11111000010
`define PAT_STUR 11'b11111000000
`define PAT_HLT  11'b11010100010

// bits 31:23
`define PAT_MOVZ 9'b110100101
`define PAT_MOVK 9'b111100101

// bits 31:26
`define PAT_B 6'b000101

`define PAT_NOP 32'hd503201f       // whole word

`endif

// ==== decode_top.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_top (
  input  logic                              clk_in,
  input  logic                              reset,
  input  logic                              flush,
  input  logic                              fetch_valid,
  input  logic                              exe_ready,
  input  uop_pkg::addr_t                    pc,
  input  isa_pkg::insn_t [`GROUP_WIDTH-1:0] fetched_ops,
  output logic                              decode_ready,
  output uop_pkg::uop_bundle_t              uops
);
  uop_pkg::slot_uops_t [`GROUP_WIDTH-1:0] slots;
  uop_pkg::uop_bundle_t                   next_bundle;

  for (genvar g = 0; g < `GROUP_WIDTH; g++) begin : gen_lane
    isa_pkg::op_class_t lane_class;

    op_classify u_classify (
      .insn     (fetched_ops[g]),
      .op_class (lane_class)
    );

    uop_former u_former (
      .insn     (fetched_ops[g]),
      .op_class (lane_class),
      .slot_pc  (pc + uop_pkg::addr_t'(4 * g)),   // slot i sits at pc + 4i
      .slot     (slots[g])
    );
  end

  uop_packer u_packer (
    .fetch_valid (fetch_valid),
    .slots       (slots),
    .bundle      (next_bundle)
  );

  issue_buffer u_issue (
    .clk_in       (clk_in),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .exe_ready    (exe_ready),
    .next_bundle  (next_bundle),
    .decode_ready (decode_ready),
    .uops         (uops)
  );

endmodule

// ==== isa_pkg.sv ====
`include "decode_defs.svh"

package isa_pkg;

  typedef logic [`INSN_BITS-1:0] insn_t;

  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  // one entry per decoded instruction family
  typedef enum logic [3:0] {
    OPC_ADD_RI,
    OPC_SUB_RI,
    OPC_ADDS,
    OPC_SUBS,
    OPC_ORR,
    OPC_EOR,
    OPC_ANDS,
    OPC_MVN,
    OPC_MOVZ,
    OPC_MOVK,
    OPC_LDUR,
    OPC_STUR,
    OPC_B,
    OPC_NOP,
    OPC_HLT,
    OPC_UNKNOWN
  } op_class_t;

endpackage

// ==== issue_buffer.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module issue_buffer (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 fetch_valid,
  input  logic                 exe_ready,
  input  uop_pkg::uop_bundle_t next_bundle,
  output logic                 decode_ready,
  output uop_pkg::uop_bundle_t uops
);
  import uop_pkg::*;

  buf_state_t  state;
  uop_bundle_t skid;
  logic        take;

  assign take = fetch_valid && decode_ready;

  always_ff @(posedge clk_in) begin
    if (reset || flush) begin
      state        <= BUF_EMPTY;
      decode_ready <= 1'b0;
      uops         <= '0;
    end else begin
      case (state)
        BUF_EMPTY: begin
          if (exe_ready) begin
            uops         <= next_bundle;   // straight through
            decode_ready <= 1'b1;
          end else if (take) begin
            state        <= BUF_FULL;
            decode_ready <= 1'b0;
          end else begin
            decode_ready <= 1'b1;
          end
        end
        BUF_FULL: begin
          if (exe_ready) begin
            uops         <= skid;
            state        <= BUF_EMPTY;
            decode_ready <= 1'b1;
          end
        end
        default: state <= BUF_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == BUF_EMPTY && !exe_ready && take)
      skid <= next_bundle;
  end

  // fetch has to hold off once the skid entry is in use
  no_fetch_when_full: assert property (@(posedge clk_in) disable iff (reset)
    state == BUF_FULL |-> !fetch_valid);

  ready_low_only_when_blocked: assert property (@(posedge clk_in) disable iff (reset)
    !decode_ready == ((state == BUF_FULL) || $past(reset || flush)));

endmodule

// ==== op_classify.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module op_classify (
  input  isa_pkg::insn_t     insn,
  output isa_pkg::op_class_t op_class
);
  import isa_pkg::*;

  always_comb begin
    if (insn == `PAT_NOP)          // whole word first
      op_class = OPC_NOP;
    else if (insn[31:22] == `PAT_ADD_RI)
      op_class = OPC_ADD_RI;
    else if (insn[31:22] == `PAT_SUB_RI)
      op_class = OPC_SUB_RI;
    else if (insn[31:21] == `PAT_ADDS)
      op_class = OPC_ADDS;
    else if (insn[31:21] == `PAT_SUBS)
      op_class = OPC_SUBS;
    else if (insn[31:21] == `PAT_ORR)
      op_class = OPC_ORR;
    else if (insn[31:21] == `PAT_MVN)
      op_class = OPC_MVN;
    else if (insn[31:21] == `PAT_EOR)
      op_class = OPC_EOR;
    else if (insn[31:21] == `PAT_ANDS)
      op_class = OPC_ANDS;
    else if (insn[31:21] == `PAT_LDUR)
      op_class = OPC_LDUR;
    else if (insn[31:21] == `PAT_STUR)
      op_class = OPC_STUR;
    else if (insn[31:21] == `PAT_HLT)
      op_class = OPC_HLT;
    else if (insn[31:23] == `PAT_MOVZ)
      op_class = OPC_MOVZ;
    else if (insn[31:23] == `PAT_MOVK)
      op_class = OPC_MOVK;
    else if (insn[31:26] == `PAT_B)
      op_class = OPC_B;
    else
      op_class = OPC_UNKNOWN;

    // an x on insn means fetch drove an undefined word into the lane
    assert (!$isunknown(insn))
      else $error("op_classify: undefined instruction word %h", insn);
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sources.f --top-module tb_decode -o tb_decode
out=$(./obj_dir/tb_decode)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Done: no errors"

// ==== sources.f ====
+incdir+.
isa_pkg.sv
uop_pkg.sv
op_classify.sv
uop_former.sv
uop_packer.sv
issue_buffer.sv
decode_top.sv
tb_decode.sv

// ==== tb_decode.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module tb_decode;
  import isa_pkg::*;
  import uop_pkg::*;

  typedef insn_t [`GROUP_WIDTH-1:0] group_t;
  typedef logic [$clog2(`GROUP_WIDTH)-1:0] lane_idx_t;
  typedef logic [$clog2(`BUNDLE_WIDTH)-1:0] slot_idx_t;

  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 8;

  logic        clk_in;
  logic        reset;
  logic        flush;
  logic        fetch_valid;
  logic        exe_ready;
  logic        decode_ready;
  addr_t       pc;
  group_t      fetched_ops;
  uop_bundle_t uops;

  logic [31:0] lfsr_state;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;
  string       test_name;

  decode_top dut_i (
    .clk_in       (clk_in),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .exe_ready    (exe_ready),
    .pc           (pc),
    .fetched_ops  (fetched_ops),
    .decode_ready (decode_ready),
    .uops         (uops)
  );

  always #5 clk_in = ~clk_in;

  // x^32 + x^22 + x^2 + x + 1, one step per bit handed out
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic insn_t enc_add_ri(logic sub, reg_idx_t rd, reg_idx_t rn, logic [11:0] imm);
    return {sub ? `PAT_SUB_RI : `PAT_ADD_RI, imm, rn, rd};
  endfunction

  function automatic insn_t enc_rr(logic [10:0] pat, reg_idx_t rm, reg_idx_t rn, reg_idx_t rd);
    return {pat, rm, 6'd0, rn, rd};
  endfunction

  function automatic insn_t enc_mov(logic [8:0] pat, logic [1:0] hw, logic [15:0] imm,
                                    reg_idx_t rd);
    return {pat, hw, imm, rd};
  endfunction

  function automatic insn_t enc_mem(logic [10:0] pat, logic [8:0] off, reg_idx_t rn,
                                    reg_idx_t rt);
    return {pat, off, 2'b00, rn, rt};
  endfunction

  function automatic insn_t random_rr();
    logic [10:0] pat;
    reg_idx_t    rd;
    reg_idx_t    rn;
    reg_idx_t    rm;
    case (take_bits(3) % 5)
      0:       pat = `PAT_ADDS;
      1:       pat = `PAT_SUBS;
      2:       pat = `PAT_EOR;
      3:       pat = `PAT_ANDS;
      default: pat = `PAT_MVN;
    endcase
    rd = reg_idx_t'(take_bits(5));
    rn = reg_idx_t'(take_bits(5));
    rm = reg_idx_t'(take_bits(5));
    return enc_rr(pat, rm, rn, rd);
  endfunction

  // expected micro-ops of one fetch slot
  function automatic slot_uops_t ref_slot(insn_t w, addr_t spc);
    slot_uops_t s;
    uop_t       u;
    uop_t       m;
    uopcode_t   rr;
    logic [8:0] off;
    logic       ld;
    s          = '0;
    u          = '0;
    u.pc       = spc;
    u.tx_begin = 1'b1;
    u.tx_end   = 1'b1;
    off        = w[20:12];
    ld         = (w[31:21] == `PAT_LDUR);
    case (w[31:21])
      `PAT_ADDS: rr = UOP_ADD;
      `PAT_SUBS: rr = UOP_SUB;
      `PAT_ORR:  rr = UOP_ORR;
      `PAT_EOR:  rr = UOP_EOR;
      `PAT_ANDS: rr = UOP_AND;
      `PAT_MVN:  rr = UOP_MVN;
      default:   rr = UOP_NOP;
    endcase
    if (w == `PAT_NOP) begin
      s.count = 2'd0;
    end else if (w[31:26] == `PAT_B) begin
      s.stop = 1'b1;
    end else if (w[31:22] == `PAT_ADD_RI || w[31:22] == `PAT_SUB_RI) begin
      u.uopcode  = w[30] ? UOP_SUB : UOP_ADD;     // op bit
      u.dst      = w[4:0];
      u.src1     = w[9:5];
      u.imm      = imm_t'(w[21:10]);
      u.src_sp   = (w[9:5] == `SP_REG);
      u.dst_sp   = (w[9:5] == `SP_REG) && (w[4:0] == `SP_REG);
      u.w_enable = 1'b1;
    end else if (rr != UOP_NOP) begin
      u.uopcode  = rr;
      u.dst      = w[4:0];
      u.src1     = w[9:5];
      u.src2     = w[20:16];
      u.valb_sel = 1'b1;
      u.w_enable = 1'b1;
    end else if (w[31:23] == `PAT_MOVZ || w[31:23] == `PAT_MOVK) begin
      u.uopcode  = w[29] ? UOP_MOVK : UOP_MOVZ;
      u.dst      = w[4:0];
      u.imm      = imm_t'(w[20:5]);
      u.hw       = w[22:21];
      u.w_enable = 1'b1;
    end else if (ld || w[31:21] == `PAT_STUR) begin
      m           = u;
      m.uopcode   = ld ? UOP_LOAD : UOP_STORE;
      m.dst       = w[4:0];
      m.src1      = (off != 9'd0) ? w[4:0] : w[9:5];
      m.mem_read  = ld;
      m.mem_write = !ld;
      m.w_enable  = ld;
      if (off != 9'd0) begin
        u.uopcode  = off[8] ? UOP_SUB : UOP_ADD;  // address add first
        u.dst      = w[4:0];
        u.src1     = w[9:5];
        u.imm      = imm_t'(off);
        u.w_enable = 1'b1;
        u.tx_end   = 1'b0;
        m.tx_begin = 1'b0;
        s.second   = m;
        s.count    = 2'd2;
      end else begin
        u = m;
      end
    end else if (w[31:21] == `PAT_HLT) begin
      u.uopcode = UOP_HLT;
    end
    if (u.uopcode != UOP_NOP) begin
      s.first = u;
      if (s.count == 2'd0)
        s.count = 2'd1;
    end
    return s;
  endfunction

  function automatic uop_bundle_t ref_bundle(group_t ops, addr_t p);
    uop_bundle_t b;
    slot_uops_t  s;
    int          n;
    logic        stopped;
    b       = '0;
    n       = 0;
    stopped = 1'b0;
    for (int i = 0; i < `GROUP_WIDTH; i++) begin
      s       = ref_slot(ops[lane_idx_t'(i)], p + addr_t'(4 * i));
      stopped = stopped || s.stop;
      if (!stopped && s.count != 2'd0) begin
        b[slot_idx_t'(n)] = s.first;
        n++;
      end
      if (!stopped && s.count == 2'd2) begin
        b[slot_idx_t'(n)] = s.second;
        n++;
      end
    end
    return b;
  endfunction

  task automatic report(int k, string field, logic [63:0] got, logic [63:0] exp);
    $display("mismatch uops[%0d].%s: got 0x%0h expected 0x%0h", k, field, got, exp);
  endtask

  task automatic check_uop(uop_t a, uop_t e, int k);
    if (a !== e) begin
      errors++;
      if (a.uopcode !== e.uopcode) report(k, "uopcode", 64'(a.uopcode), 64'(e.uopcode));
      if (a.dst !== e.dst) report(k, "dst", 64'(a.dst), 64'(e.dst));
      if (a.src1 !== e.src1) report(k, "src1", 64'(a.src1), 64'(e.src1));
      if (a.src2 !== e.src2) report(k, "src2", 64'(a.src2), 64'(e.src2));
      if (a.dst_sp !== e.dst_sp) report(k, "dst_sp", 64'(a.dst_sp), 64'(e.dst_sp));
      if (a.src_sp !== e.src_sp) report(k, "src_sp", 64'(a.src_sp), 64'(e.src_sp));
      if (a.imm !== e.imm) report(k, "imm", 64'(a.imm), 64'(e.imm));
      if (a.hw !== e.hw) report(k, "hw", 64'(a.hw), 64'(e.hw));
      if (a.valb_sel !== e.valb_sel) report(k, "valb_sel", 64'(a.valb_sel), 64'(e.valb_sel));
      if (a.mem_read !== e.mem_read) report(k, "mem_read", 64'(a.mem_read), 64'(e.mem_read));
      if (a.mem_write !== e.mem_write) report(k, "mem_write", 64'(a.mem_write), 64'(e.mem_write));
      if (a.w_enable !== e.w_enable) report(k, "w_enable", 64'(a.w_enable), 64'(e.w_enable));
      if (a.tx_begin !== e.tx_begin) report(k, "tx_begin", 64'(a.tx_begin), 64'(e.tx_begin));
      if (a.tx_end !== e.tx_end) report(k, "tx_end", 64'(a.tx_end), 64'(e.tx_end));
      if (a.pc !== e.pc) report(k, "pc", a.pc, e.pc);
    end
  endtask

  task automatic check_bundle(uop_bundle_t exp);
    for (int k = 0; k < `BUNDLE_WIDTH; k++)
      check_uop(uops[slot_idx_t'(k)], exp[slot_idx_t'(k)], k);
  endtask

  task automatic check_ready(logic got, logic exp, string when);
    if (got !== exp) begin
      errors++;
      $display("mismatch decode_ready (%s): got 0x%0h expected 0x%0h", when, got, exp);
    end
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk_in);
    while (decode_ready !== 1'b1 && n < 50) begin
      @(negedge clk_in);
      n++;
    end
    if (decode_ready !== 1'b1) begin
      errors++;
      $display("timeout: decode_ready stayed low for %0d cycles", n);
    end
  endtask

  // returns right after the edge that takes the group
  task automatic present(addr_t p, group_t ops);
    wait_ready();
    @(posedge clk_in);
    fetch_valid <= 1'b1;
    pc          <= p;
    fetched_ops <= ops;
    @(posedge clk_in);
    fetch_valid <= 1'b0;
  endtask

  task automatic run_group(addr_t p, group_t ops);
    present(p, ops);
    @(negedge clk_in);                  // issued one cycle after the take
    check_bundle(ref_bundle(ops, p));
  endtask

  task automatic test_reset();
    start_test("reset");
    for (int c = 0; c < 8; c++) begin
      @(posedge clk_in);
      if (c == 7)
        reset <= 1'b0;
      @(negedge clk_in);
      check_ready(decode_ready, 1'b0, "in reset");
      check_bundle('0);
    end
    @(negedge clk_in);
    check_ready(decode_ready, 1'b1, "after reset");
    finish_test();
  endtask

  task automatic test_alu_move();
    group_t g;
    start_test("alu and move decode");
    g[0] = enc_add_ri(1'b0, 5'd3, `SP_REG, 12'h02a);
    g[1] = enc_rr(`PAT_ORR, 5'd6, 5'd5, 5'd4);
    run_group(64'h1000, g);
    g[0] = enc_mov(`PAT_MOVZ, 2'd2, 16'hbeef, 5'd7);
    g[1] = enc_mov(`PAT_MOVK, 2'd1, 16'h1234, 5'd7);
    run_group(64'h1008, g);
    g[0] = enc_add_ri(1'b1, `SP_REG, `SP_REG, 12'hfff);
    g[1] = enc_rr(`PAT_SUBS, 5'd2, 5'd1, `SP_REG);   // cmp
    run_group(64'h1010, g);
    finish_test();
  endtask

  task automatic test_mem_crack();
    group_t g;
    start_test("memory cracking");
    g[0] = enc_mem(`PAT_LDUR, 9'h010, 5'd9, 5'd8);
    g[1] = enc_mem(`PAT_STUR, 9'h000, 5'd11, 5'd10);
    run_group(64'h3000, g);
    g[0] = enc_mem(`PAT_LDUR, 9'h1f0, 5'd2, 5'd1);   // negative offset
    g[1] = enc_mem(`PAT_STUR, 9'h005, 5'd4, 5'd3);
    run_group(64'h3008, g);
    finish_test();
  endtask

  task automatic test_stop_nop();
    group_t g;
    start_test("group stop and nop");
    g[0] = {`PAT_B, 26'h10};
    g[1] = {`PAT_HLT, 21'd0};
    run_group(64'h5000, g);
    g[0] = `PAT_NOP;
    run_group(64'h5008, g);
    finish_test();
  endtask

  task automatic test_backpressure();
    group_t a;
    group_t b;
    start_test("back-pressure and flush");
    a[0] = enc_add_ri(1'b0, 5'd1, 5'd2, 12'h011);
    a[1] = enc_rr(`PAT_EOR, 5'd3, 5'd4, 5'd5);
    b[0] = enc_mov(`PAT_MOVZ, 2'd3, 16'h00ff, 5'd9);
    b[1] = {`PAT_HLT, 21'd0};
    present(64'h2000, a);
    exe_ready <= 1'b0;                  // a issues, then execute stalls
    present(64'h2008, b);
    for (int c = 0; c < 3; c++) begin
      @(negedge clk_in);
      check_ready(decode_ready, 1'b0, "buffer full");
      check_bundle(ref_bundle(a, 64'h2000));
    end
    @(posedge clk_in);
    exe_ready <= 1'b1;
    @(posedge clk_in);
    @(negedge clk_in);
    check_bundle(ref_bundle(b, 64'h2008));
    check_ready(decode_ready, 1'b1, "buffer drained");
    present(64'h2010, a);
    exe_ready <= 1'b0;
    present(64'h2018, b);
    @(negedge clk_in);
    check_ready(decode_ready, 1'b0, "full before flush");
    check_bundle(ref_bundle(a, 64'h2010));
    @(posedge clk_in);
    flush <= 1'b1;
    @(posedge clk_in);
    flush <= 1'b0;
    @(negedge clk_in);
    check_ready(decode_ready, 1'b0, "after flush");
    check_bundle('0);
    @(negedge clk_in);
    check_ready(decode_ready, 1'b1, "cycle after flush");
    @(posedge clk_in);
    exe_ready <= 1'b1;
    finish_test();
  endtask

  task automatic test_random_regs();
    group_t g;
    start_test("random register fields");
    for (int n = 0; n < 20; n++) begin
      g[0] = random_rr();
      g[1] = random_rr();
      run_group(64'h4000 + addr_t'(8 * n), g);
    end
    finish_test();
  endtask

  initial begin
    clk_in       = 1'b0;
    reset        = 1'b1;
    flush        = 1'b0;
    fetch_valid  = 1'b0;
    exe_ready    = 1'b1;
    pc           = '0;
    fetched_ops  = {`GROUP_WIDTH{`PAT_NOP}};
    lfsr_state   = 32'hb3ccb9ed;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset();
    test_alu_move();
    test_mem_crack();
    test_stop_nop();
    test_backpressure();
    test_random_regs();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== uop_former.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module uop_former (
  input  isa_pkg::insn_t      insn,
  input  isa_pkg::op_class_t  op_class,
  input  uop_pkg::addr_t      slot_pc,
  output uop_pkg::slot_uops_t slot
);
  import isa_pkg::*;
  import uop_pkg::*;

  reg_idx_t   rd;                  // also rt for ldur/stur
  reg_idx_t   rn;
  reg_idx_t   rm;
  logic [8:0] offset;
  logic       cracked;
  logic       is_load;
  uop_t       op;
  uop_t       mem_op;

  assign rd      = insn[4:0];
  assign rn      = insn[9:5];
  assign rm      = insn[20:16];
  assign offset  = insn[20:12];
  assign cracked = (offset != 9'd0);
  assign is_load = (op_class == OPC_LDUR);

  always_comb begin
    op          = '0;
    op.pc       = slot_pc;
    op.tx_begin = 1'b1;
    op.tx_end   = 1'b1;
    mem_op      = op;
    slot        = '0;
    case (op_class)
      OPC_ADD_RI, OPC_SUB_RI: begin
        op.uopcode  = (op_class == OPC_SUB_RI) ? UOP_SUB : UOP_ADD;
        op.dst      = rd;
        op.src1     = rn;
        op.imm      = imm_t'(insn[21:10]);
        op.src_sp   = (rn == `SP_REG);
        op.dst_sp   = (rd == `SP_REG) && (rn == `SP_REG);
        op.w_enable = 1'b1;
        slot.first  = op;
        slot.count  = 2'd1;
      end
      OPC_ADDS, OPC_SUBS, OPC_ORR, OPC_EOR, OPC_ANDS, OPC_MVN: begin
        case (op_class)
          OPC_SUBS: op.uopcode = UOP_SUB;
          OPC_ORR:  op.uopcode = UOP_ORR;
          OPC_EOR:  op.uopcode = UOP_EOR;
          OPC_ANDS: op.uopcode = UOP_AND;
          OPC_MVN:  op.uopcode = UOP_MVN;
          default:  op.uopcode = UOP_ADD;
        endcase
        op.dst      = rd;
        op.src1     = rn;
        op.src2     = rm;
        op.valb_sel = 1'b1;
        op.w_enable = 1'b1;
        slot.first  = op;
        slot.count  = 2'd1;
      end
      OPC_MOVZ, OPC_MOVK: begin
        op.uopcode  = (op_class == OPC_MOVK) ? UOP_MOVK : UOP_MOVZ;
        op.dst      = rd;
        op.imm      = imm_t'(insn[20:5]);
        op.hw       = insn[22:21];
        op.w_enable = 1'b1;
        slot.first  = op;
        slot.count  = 2'd1;
      end
      OPC_LDUR, OPC_STUR: begin
        mem_op.uopcode   = is_load ? UOP_LOAD : UOP_STORE;
        mem_op.dst       = rd;
        mem_op.src1      = cracked ? rd : rn;   // cracked access uses the add result
        mem_op.mem_read  = is_load;
        mem_op.mem_write = !is_load;
        mem_op.w_enable  = is_load;
        if (cracked) begin
          op.uopcode      = insn[20] ? UOP_SUB : UOP_ADD;
          op.dst          = rd;
          op.src1         = rn;
          op.imm          = imm_t'(offset);
          op.w_enable     = 1'b1;
          op.tx_end       = 1'b0;
          mem_op.tx_begin = 1'b0;
          slot.first      = op;
          slot.second     = mem_op;
          slot.count      = 2'd2;
        end else begin
          slot.first = mem_op;
          slot.count = 2'd1;
        end
      end
      OPC_HLT: begin
        op.uopcode = UOP_HLT;
        slot.first = op;
        slot.count = 2'd1;
      end
      OPC_B: slot.stop = 1'b1;        // taken at fetch, nothing to issue
      default: slot.count = 2'd0;     // nop and unknown
    endcase
  end

endmodule

// ==== uop_packer.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module uop_packer (
  input  logic                                   fetch_valid,
  input  uop_pkg::slot_uops_t [`GROUP_WIDTH-1:0] slots,
  output uop_pkg::uop_bundle_t                   bundle
);
  import uop_pkg::*;

  logic [$clog2(`BUNDLE_WIDTH)-1:0] idx;      // next free bundle index
  logic [$clog2(`BUNDLE_WIDTH):0]   total;
  logic                             stopped;

  always_comb begin
    bundle  = '0;                  // all-nop padding
    idx     = '0;
    total   = '0;
    stopped = 1'b0;
    for (int i = 0; i < `GROUP_WIDTH; i++) begin
      total = total + {1'b0, slots[i].count};
      if (fetch_valid && !stopped) begin
        if (slots[i].stop) begin
          stopped = 1'b1;
        end else begin
          if (slots[i].count != 2'd0) begin
            bundle[idx] = slots[i].first;
            idx         = idx + 1'b1;
          end
          if (slots[i].count == 2'd2) begin
            bundle[idx] = slots[i].second;
            idx         = idx + 1'b1;
          end
        end
      end
    end

    // the formers together must never overflow a bundle
    assert (total <= `BUNDLE_WIDTH)
      else $error("uop_packer: %0d uops exceed the bundle", total);
  end

endmodule

// ==== uop_pkg.sv ====
`include "decode_defs.svh"

package uop_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [20:0] imm_t;

  typedef enum logic [3:0] {
    UOP_NOP = 4'd0,                // all-zero uop is a nop
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_ORR,
    UOP_EOR,
    UOP_MVN,
    UOP_MOVZ,
    UOP_MOVK,
    UOP_LOAD,
    UOP_STORE,
    UOP_HLT
  } uopcode_t;

  typedef struct packed {
    uopcode_t          uopcode;
    isa_pkg::reg_idx_t dst;
    isa_pkg::reg_idx_t src1;
    isa_pkg::reg_idx_t src2;
    logic              dst_sp;
    logic              src_sp;
    imm_t              imm;
    logic [1:0]        hw;         // movz/movk shift
    logic              valb_sel;   // 1 = register operand
    logic              mem_read;
    logic              mem_write;
    logic              w_enable;
    logic              tx_begin;
    logic              tx_end;
    addr_t             pc;
  } uop_t;

  typedef struct packed {
    uop_t       first;
    uop_t       second;
    logic [1:0] count;
    logic       stop;              // group ends at this slot
  } slot_uops_t;

  typedef uop_t [`BUNDLE_WIDTH-1:0] uop_bundle_t;

  typedef enum logic {
    BUF_EMPTY,
    BUF_FULL
  } buf_state_t;

endpackage
